// ==== build.f ====
+incdir+dv
rtl/mips_pkg.sv
rtl/dcd_if.sv
rtl/inst_decoder.sv
rtl/pc_unit.sv
rtl/reg_file.sv
rtl/mips_alu.sv
rtl/mem_stage.sv
rtl/mips_core.sv
dv/tb_mips_core.sv

// ==== dv/mips_ref.svh ====
// ===========================================================================
// mips reference model
// architectural registers, data window and PC of the core, a per-instruction
// step that predicts port activity, and the random program generator
// ===========================================================================
`ifndef MIPS_REF_SVH
`define MIPS_REF_SVH

mips_pkg::word_t ref_regs [32];
mips_pkg::word_t ref_mem [data_words];
mips_pkg::word_t ref_pc;
logic            ref_halted;

// byte lane 0 is the most significant byte
function automatic logic [7:0] lane_byte(mips_pkg::word_t w, logic [1:0] lane);
   case (lane)
      2'd0:    return w[31:24];
      2'd1:    return w[23:16];
      2'd2:    return w[15:8];
      default: return w[7:0];
   endcase
endfunction

function automatic mips_pkg::word_t lane_put(mips_pkg::word_t w, logic [1:0] lane,
                                             logic [7:0] v);
   mips_pkg::word_t r;
   r = w;
   case (lane)
      2'd0:    r[31:24] = v;
      2'd1:    r[23:16] = v;
      2'd2:    r[15:8]  = v;
      default: r[7:0]   = v;
   endcase
   return r;
endfunction

function automatic void ref_reset();
   ref_regs   = '{default: '0};
   ref_pc     = text_start;
   ref_halted = 1'b0;
   for (int i = 0; i < data_words; i++) begin
      ref_mem[6'(i)] = pattern_word(i);
   end
endfunction

// one instruction of architectural state, returns what the ports must show
function automatic void ref_step(output logic [29:0] exp_iaddr, output logic [3:0] exp_we,
                                 output logic exp_access, output logic [29:0] exp_maddr,
                                 output mips_pkg::word_t exp_wdata);
   mips_pkg::word_t ins;
   mips_pkg::word_t a;
   mips_pkg::word_t b;
   mips_pkg::word_t sx;
   mips_pkg::word_t zx;
   mips_pkg::word_t addr;
   mips_pkg::word_t res;
   mips_pkg::word_t nxt;
   logic [7:0]      slot_i;
   logic [4:0]      rd;
   logic            wr;

   exp_iaddr  = ref_pc[31:2];
   exp_we     = 4'b0000;
   exp_access = 1'b0;
   exp_maddr  = '0;
   exp_wdata  = '0;
   // frozen on the syscall, nothing else happens
   if (ref_halted) return;

   slot_i = 8'((ref_pc - text_start) >> 2);
   ins    = prog[slot_i];
   a      = ref_regs[ins[25:21]];
   b      = ref_regs[ins[20:16]];
   sx     = {{16{ins[15]}}, ins[15:0]};
   zx     = {16'h0000, ins[15:0]};
   addr   = a + sx;
   nxt    = ref_pc + 32'd4;
   rd     = ins[20:16];
   wr     = 1'b1;
   res    = '0;

   case (ins[31:26])
      mips_pkg::op_special: begin
         rd = ins[15:11];
         case (ins[5:0])
            mips_pkg::fn_sll:  res = b << ins[10:6];
            mips_pkg::fn_srl:  res = b >> ins[10:6];
            mips_pkg::fn_sra:  res = $signed(b) >>> ins[10:6];
            mips_pkg::fn_addu: res = a + b;
            mips_pkg::fn_subu: res = a - b;
            mips_pkg::fn_and:  res = a & b;
            mips_pkg::fn_or:   res = a | b;
            mips_pkg::fn_xor:  res = a ^ b;
            mips_pkg::fn_nor:  res = ~(a | b);
            mips_pkg::fn_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            mips_pkg::fn_sltu: res = (a < b) ? 32'd1 : 32'd0;
            mips_pkg::fn_syscall: begin
               // halted shows up one cycle later, pc stays put
               wr         = 1'b0;
               ref_halted = 1'b1;
               nxt        = ref_pc;
            end
            default: wr = 1'b0;
         endcase
      end
      mips_pkg::op_addiu: res = a + sx;
      mips_pkg::op_slti:  res = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
      mips_pkg::op_andi:  res = a & zx;
      mips_pkg::op_ori:   res = a | zx;
      mips_pkg::op_xori:  res = a ^ zx;
      mips_pkg::op_lui:   res = {ins[15:0], 16'h0000};
      mips_pkg::op_lw, mips_pkg::op_lbu: begin
         exp_access = 1'b1;
         exp_maddr  = addr[31:2];
         if (ins[31:26] == mips_pkg::op_lw) begin
            res = ref_mem[addr[7:2]];
         end else begin
            res = {24'h000000, lane_byte(ref_mem[addr[7:2]], addr[1:0])};
         end
      end
      mips_pkg::op_sw: begin
         wr                = 1'b0;
         exp_access        = 1'b1;
         exp_maddr         = addr[31:2];
         exp_we            = 4'b1111;
         exp_wdata         = b;
         ref_mem[addr[7:2]] = b;
      end
      mips_pkg::op_sb: begin
         wr                 = 1'b0;
         exp_access         = 1'b1;
         exp_maddr          = addr[31:2];
         // mem_we bit 3 enables byte 0
         exp_we             = 4'b0001 << (2'd3 - addr[1:0]);
         exp_wdata          = lane_put('0, addr[1:0], b[7:0]);
         ref_mem[addr[7:2]] = lane_put(ref_mem[addr[7:2]], addr[1:0], b[7:0]);
      end
      mips_pkg::op_beq: begin
         wr = 1'b0;
         if (a == b) nxt = ref_pc + 32'd4 + {sx[29:0], 2'b00};
      end
      mips_pkg::op_bne: begin
         wr = 1'b0;
         if (a != b) nxt = ref_pc + 32'd4 + {sx[29:0], 2'b00};
      end
      mips_pkg::op_j: begin
         wr  = 1'b0;
         nxt = {ref_pc[31:28], ins[25:0], 2'b00};
      end
      default: wr = 1'b0;
   endcase

   if (wr && (rd != 5'd0)) ref_regs[rd] = res;
   ref_pc = nxt;
endfunction

function automatic mips_pkg::word_t rtype_word(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                               logic [4:0] shamt, logic [5:0] funct);
   return {mips_pkg::op_special, rs, rt, rd, shamt, funct};
endfunction

function automatic mips_pkg::word_t itype_word(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                               logic [15:0] imm);
   return {op, rs, rt, imm};
endfunction

// absolute jump to a program slot
function automatic mips_pkg::word_t jump_word(int unsigned slot);
   mips_pkg::word_t dest;
   dest = text_start + 32'(slot) * 32'd4;
   return {mips_pkg::op_j, dest[27:2]};
endfunction

function automatic void place_inst(int unsigned slot, mips_pkg::word_t w);
   prog[8'(slot)] = w;
endfunction

// random byte offset inside the data window 0x100 to 0x1ff
function automatic logic [15:0] window_offset(logic word_only);
   logic [15:0] off;
   off = 16'h0100 + 16'($urandom_range(0, 255));
   if (word_only) off[1:0] = 2'b00;
   return off;
endfunction

// every result is pushed out through a sw or sb with $zero as base
function automatic void store_result(int unsigned slot, logic [4:0] r);
   logic is_sw;
   is_sw = ($urandom_range(0, 1) == 0);
   place_inst(slot, itype_word(is_sw ? mips_pkg::op_sw : mips_pkg::op_sb, 5'd0, r,
                               window_offset(is_sw)));
endfunction

function automatic void build_program();
   logic [5:0]  r_fn [11] = '{mips_pkg::fn_sll, mips_pkg::fn_srl, mips_pkg::fn_sra,
                              mips_pkg::fn_addu, mips_pkg::fn_subu, mips_pkg::fn_and,
                              mips_pkg::fn_or, mips_pkg::fn_xor, mips_pkg::fn_nor,
                              mips_pkg::fn_slt, mips_pkg::fn_sltu};
   logic [5:0]  i_op [6] = '{mips_pkg::op_addiu, mips_pkg::op_slti, mips_pkg::op_andi,
                             mips_pkg::op_ori, mips_pkg::op_xori, mips_pkg::op_lui};
   int unsigned slot;
   int unsigned room;
   int unsigned kind;
   int unsigned gap;
   logic [4:0]  dst;
   logic [4:0]  src;
   logic [4:0]  alt;
   logic        is_lw;

   slot = 0;
   while (slot < prog_len - 1) begin
      // slots left before the closing syscall
      room = prog_len - 1 - slot;
      kind = (room < 2) ? 8 : $urandom_range(0, 9);
      dst  = 5'($urandom_range(0, 31));
      src  = 5'($urandom_range(0, 31));
      alt  = 5'($urandom_range(0, 31));
      if (kind < 4) begin
         // shamt is ignored outside the shift functs
         place_inst(slot, rtype_word(src, alt, dst, 5'($urandom_range(0, 31)),
                                     r_fn[4'($urandom_range(0, 10))]));
         store_result(slot + 1, dst);
         slot += 2;
      end else if (kind < 7) begin
         place_inst(slot, itype_word(i_op[3'($urandom_range(0, 5))], src, dst,
                                     16'($urandom())));
         store_result(slot + 1, dst);
         slot += 2;
      end else if (kind == 7) begin
         is_lw = ($urandom_range(0, 1) == 0);
         place_inst(slot, itype_word(is_lw ? mips_pkg::op_lw : mips_pkg::op_lbu, 5'd0, dst,
                                     window_offset(is_lw)));
         store_result(slot + 1, dst);
         slot += 2;
      end else begin
         // forward only, never past the syscall
         gap = $urandom_range(0, (room > 4) ? 3 : room - 1);
         if (kind == 9) begin
            place_inst(slot, jump_word(slot + 1 + gap));
         end else begin
            // same register on both sides forces a taken beq
            if ($urandom_range(0, 1) == 0) alt = src;
            place_inst(slot, itype_word(($urandom_range(0, 1) == 0) ? mips_pkg::op_beq :
                                        mips_pkg::op_bne, src, alt, 16'(gap)));
         end
         slot += 1;
      end
   end
   place_inst(prog_len - 1, rtype_word(5'd0, 5'd0, 5'd0, 5'd0, mips_pkg::fn_syscall));
endfunction

`endif

// ==== dv/tb_mips_core.sv ====
// ===========================================================================
// tb_mips_core
// testbench for the single-cycle MIPS core: random program, instruction
// and data memories, per-cycle comparison against a reference model
// ===========================================================================
`timescale 1ns/1ns

module tb_mips_core;

   localparam mips_pkg::word_t text_start = 32'h0040_0000;
   localparam int prog_len     = 256;
   localparam int data_words   = 64;
   localparam int clk_period   = 4;
   localparam int reset_cycles = 4;
   // forward-only code runs each slot at most once
   localparam int watchdog_ns  = prog_len * clk_period * 4 + reset_cycles * clk_period;

   logic            clk = 1'b0;
   logic            rst_b;
   logic [29:0]     inst_addr;
   mips_pkg::word_t inst;
   logic [29:0]     mem_addr;
   mips_pkg::word_t mem_rdata;
   mips_pkg::word_t mem_wdata;
   logic [3:0]      mem_we;
   logic            halted;

   mips_pkg::word_t prog [prog_len];
   mips_pkg::word_t dmem [data_words];
   logic [7:0]      imem_idx;
   int              halt_cycles = 0;

   // expected port values for the current cycle
   logic [29:0]     exp_iaddr;
   logic [3:0]      exp_we;
   logic            exp_access;
   logic [29:0]     exp_maddr;
   mips_pkg::word_t exp_wdata;

   // initial data contents, distinct for every word address
   function automatic mips_pkg::word_t pattern_word(int unsigned idx);
      return 32'h6a09_e667 ^ (idx * 32'h9e37_79b9) ^ (idx << 16);
   endfunction

   function automatic mips_pkg::word_t lane_mask(logic [3:0] we);
      return {{8{we[3]}}, {8{we[2]}}, {8{we[1]}}, {8{we[0]}}};
   endfunction

   `include "mips_ref.svh"

   task automatic check_value(input string name, input mips_pkg::word_t got,
                              input mips_pkg::word_t exp);
      if (got !== exp) begin
         $display("mismatch %s: got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
         $display("*** TEST FAILED ***");
         $fatal(1, "stopped at the first wrong value");
      end
   endtask

   mips_core #(.text_start(text_start)) dut_i (
      .clk       (clk),
      .rst_b     (rst_b),
      .inst_addr (inst_addr),
      .inst      (inst),
      .mem_addr  (mem_addr),
      .mem_rdata (mem_rdata),
      .mem_wdata (mem_wdata),
      .mem_we    (mem_we),
      .halted    (halted)
   );

   always #(clk_period / 2) clk = ~clk;

   // combinational instruction and data reads
   assign imem_idx  = 8'(inst_addr - text_start[31:2]);
   assign inst      = prog[imem_idx];
   assign mem_rdata = dmem[mem_addr[5:0]];

   // byte lane writes on the edge, ignored while reset is held
   always @(posedge clk) begin
      if (rst_b) begin
         if (mem_we[3]) dmem[mem_addr[5:0]][31:24] <= mem_wdata[31:24];
         if (mem_we[2]) dmem[mem_addr[5:0]][23:16] <= mem_wdata[23:16];
         if (mem_we[1]) dmem[mem_addr[5:0]][15:8]  <= mem_wdata[15:8];
         if (mem_we[0]) dmem[mem_addr[5:0]][7:0]   <= mem_wdata[7:0];
      end
   end

   // outputs are settled mid-cycle, compare on the falling edge
   always @(negedge clk) begin
      if (!rst_b) begin
         check_value("inst_addr", {2'b00, inst_addr}, {2'b00, text_start[31:2]});
         check_value("halted", {31'd0, halted}, 32'd0);
      end else begin
         check_value("halted", {31'd0, halted}, {31'd0, ref_halted});
         ref_step(exp_iaddr, exp_we, exp_access, exp_maddr, exp_wdata);
         check_value("inst_addr", {2'b00, inst_addr}, {2'b00, exp_iaddr});
         check_value("mem_we", {28'h0, mem_we}, {28'h0, exp_we});
         if (exp_access) check_value("mem_addr", {2'b00, mem_addr}, {2'b00, exp_maddr});
         // only enabled lanes of the write data carry meaning
         if (exp_we != 4'b0000) begin
            check_value("mem_wdata", mem_wdata & lane_mask(exp_we),
                        exp_wdata & lane_mask(exp_we));
         end
         if (halted) halt_cycles = halt_cycles + 1;
      end
   end

   initial begin
      rst_b = 1'b0;
      void'($urandom(32'h8475d9db));
      build_program();
      ref_reset();
      for (int i = 0; i < data_words; i++) begin
         dmem[6'(i)] = pattern_word(i);
      end
      repeat (reset_cycles) @(posedge clk);
      rst_b <= 1'b1;
      // a few halted cycles show that fetch stays frozen
      wait (halt_cycles >= 3);
      $display("*** TEST PASSED ***");
      $finish;
   end

   initial begin
      #(watchdog_ns);
      $display("watchdog expired after %0d ns without the core halting", watchdog_ns);
      $display("*** TEST FAILED ***");
      $fatal(1, "simulation timed out");
   end

endmodule

// ==== rtl/dcd_if.sv ====
// ===========================================================================
// dcd_if
// decoded control bundle, driven by the decoder and read by the fetch,
// register, execute and memory stages through their own modports
// ===========================================================================
`timescale 1ns/1ns

interface dcd_if;

   mips_pkg::alu_op_e  alu_op;
   logic               use_imm;
   // immediate already extended to a full word
   mips_pkg::word_t    imm;
   logic [4:0]         shamt;
   mips_pkg::reg_idx_t rs;
   mips_pkg::reg_idx_t rt;
   mips_pkg::reg_idx_t wr_idx;
   // never set when wr_idx is zero
   logic               reg_we;
   mips_pkg::mem_op_e  mem_op;
   mips_pkg::branch_e  branch;
   logic [25:0]        target;
   logic               syscall;

   modport decoder (
      output alu_op, use_imm, imm, shamt, rs, rt, wr_idx, reg_we,
      output mem_op, branch, target, syscall
   );

   modport fetch (input imm, branch, target, syscall);

   modport regs (input rs, rt, wr_idx, reg_we);

   modport exec (input alu_op, use_imm, imm, shamt, branch);

   modport mem (input mem_op);

endinterface

// ==== rtl/inst_decoder.sv ====
// ===========================================================================
// inst_decoder
// splits the instruction word into fields and derives ALU, immediate,
// destination, memory and control-flow controls; unknown encodings are no-ops
// ===========================================================================
`timescale 1ns/1ns

module inst_decoder (
   input  mips_pkg::word_t inst,
   dcd_if.decoder          dcd
);

   mips_pkg::opcode_e op;
   mips_pkg::funct_e  funct;
   logic              zero_ext;
   logic              we;

   assign op    = mips_pkg::opcode_e'(inst[31:26]);
   assign funct = mips_pkg::funct_e'(inst[5:0]);

   // logical immediates take a zero extended operand
   assign zero_ext = (op == mips_pkg::op_andi) || (op == mips_pkg::op_ori) ||
                     (op == mips_pkg::op_xori);

   assign dcd.rs     = inst[25:21];
   assign dcd.rt     = inst[20:16];
   assign dcd.shamt  = inst[10:6];
   assign dcd.target = inst[25:0];
   assign dcd.imm    = zero_ext ? {16'h0000, inst[15:0]} : {{16{inst[15]}}, inst[15:0]};

   always_comb begin
      dcd.alu_op  = mips_pkg::alu_add;
      dcd.use_imm = 1'b0;
      dcd.wr_idx  = inst[20:16];
      dcd.mem_op  = mips_pkg::mem_none;
      dcd.branch  = mips_pkg::br_none;
      dcd.syscall = 1'b0;
      we          = 1'b0;
      case (op)
         mips_pkg::op_special: begin
            // r-type writes rd
            dcd.wr_idx = inst[15:11];
            we         = 1'b1;
            case (funct)
               mips_pkg::fn_sll:     dcd.alu_op = mips_pkg::alu_sll;
               mips_pkg::fn_srl:     dcd.alu_op = mips_pkg::alu_srl;
               mips_pkg::fn_sra:     dcd.alu_op = mips_pkg::alu_sra;
               mips_pkg::fn_addu:    dcd.alu_op = mips_pkg::alu_add;
               mips_pkg::fn_subu:    dcd.alu_op = mips_pkg::alu_sub;
               mips_pkg::fn_and:     dcd.alu_op = mips_pkg::alu_and;
               mips_pkg::fn_or:      dcd.alu_op = mips_pkg::alu_or;
               mips_pkg::fn_xor:     dcd.alu_op = mips_pkg::alu_xor;
               mips_pkg::fn_nor:     dcd.alu_op = mips_pkg::alu_nor;
               mips_pkg::fn_slt:     dcd.alu_op = mips_pkg::alu_slt;
               mips_pkg::fn_sltu:    dcd.alu_op = mips_pkg::alu_sltu;
               mips_pkg::fn_syscall: begin
                  dcd.syscall = 1'b1;
                  we          = 1'b0;
               end
               default:              we = 1'b0;
            endcase
         end
         mips_pkg::op_j:   dcd.branch = mips_pkg::br_jump;
         // branches compare rs against rt, the ALU result is unused
         mips_pkg::op_beq: dcd.branch = mips_pkg::br_beq;
         mips_pkg::op_bne: dcd.branch = mips_pkg::br_bne;
         mips_pkg::op_addiu, mips_pkg::op_slti, mips_pkg::op_andi,
         mips_pkg::op_ori, mips_pkg::op_xori, mips_pkg::op_lui: begin
            dcd.use_imm = 1'b1;
            we          = 1'b1;
            case (op)
               mips_pkg::op_slti: dcd.alu_op = mips_pkg::alu_slt;
               mips_pkg::op_andi: dcd.alu_op = mips_pkg::alu_and;
               mips_pkg::op_ori:  dcd.alu_op = mips_pkg::alu_or;
               mips_pkg::op_xori: dcd.alu_op = mips_pkg::alu_xor;
               mips_pkg::op_lui:  dcd.alu_op = mips_pkg::alu_lui;
               default:           dcd.alu_op = mips_pkg::alu_add;
            endcase
         end
         mips_pkg::op_lw, mips_pkg::op_lbu: begin
            // address is rs plus the sign extended offset
            dcd.use_imm = 1'b1;
            dcd.mem_op  = (op == mips_pkg::op_lw) ? mips_pkg::mem_lw : mips_pkg::mem_lbu;
            we          = 1'b1;
         end
         mips_pkg::op_sw, mips_pkg::op_sb: begin
            dcd.use_imm = 1'b1;
            dcd.mem_op  = (op == mips_pkg::op_sw) ? mips_pkg::mem_sw : mips_pkg::mem_sb;
         end
         default: we = 1'b0;
      endcase
   end

   // writes to $zero are dropped here and nowhere else
   assign dcd.reg_we = we && (dcd.wr_idx != 5'd0);

endmodule

// ==== rtl/mem_stage.sv ====
// ===========================================================================
// mem_stage
// data port access: store lane alignment and byte enables, load byte
// extraction and selection of the register write-back value
// ===========================================================================
`timescale 1ns/1ns

module mem_stage (
   dcd_if.mem              dcd,
   input  mips_pkg::word_t result,
   input  mips_pkg::word_t rt_data,
   input  mips_pkg::word_t mem_rdata,
   output logic [29:0]     mem_addr,
   output mips_pkg::word_t mem_wdata,
   output logic [3:0]      mem_we,
   output mips_pkg::word_t wr_data
);

   logic [1:0]      offset;
   mips_pkg::word_t rd_shift;

   assign mem_addr = result[31:2];
   assign offset   = result[1:0];

   // big endian lanes, byte 0 sits in bits 31:24 under mem_we[3]
   assign rd_shift = mem_rdata << {offset, 3'b000};

   always_comb begin
      mem_wdata = rt_data;
      mem_we    = 4'b0000;
      case (dcd.mem_op)
         mips_pkg::mem_sw: mem_we = 4'b1111;
         mips_pkg::mem_sb: begin
            mem_wdata = {rt_data[7:0], 24'h000000} >> {offset, 3'b000};
            mem_we    = 4'b1000 >> offset;
         end
         default: mem_we = 4'b0000;
      endcase
   end

   always_comb begin
      case (dcd.mem_op)
         mips_pkg::mem_lw:  wr_data = mem_rdata;
         mips_pkg::mem_lbu: wr_data = {24'h000000, rd_shift[31:24]};
         default:           wr_data = result;
      endcase
   end

   // no byte enable may escape on anything but a store
   always_comb begin
      a_we_store_only: assert ((mem_we == 4'b0000) || (dcd.mem_op == mips_pkg::mem_sw) ||
                               (dcd.mem_op == mips_pkg::mem_sb))
         else $error("mem_we set without a store");
   end

endmodule

// ==== rtl/mips_alu.sv ====
// ===========================================================================
// mips_alu
// arithmetic, logic, shift and compare unit; also resolves whether the
// current branch or jump redirects the PC
// ===========================================================================
`timescale 1ns/1ns

module mips_alu (
   dcd_if.exec             dcd,
   input  mips_pkg::word_t rs_data,
   input  mips_pkg::word_t rt_data,
   output mips_pkg::word_t result,
   output logic            taken
);

   mips_pkg::word_t op_b;

   assign op_b = dcd.use_imm ? dcd.imm : rt_data;

   always_comb begin
      case (dcd.alu_op)
         mips_pkg::alu_add:  result = rs_data + op_b;
         mips_pkg::alu_sub:  result = rs_data - op_b;
         mips_pkg::alu_and:  result = rs_data & op_b;
         mips_pkg::alu_or:   result = rs_data | op_b;
         mips_pkg::alu_xor:  result = rs_data ^ op_b;
         mips_pkg::alu_nor:  result = ~(rs_data | op_b);
         mips_pkg::alu_slt:  result = {31'd0, $signed(rs_data) < $signed(op_b)};
         mips_pkg::alu_sltu: result = {31'd0, rs_data < op_b};
         // shifts act on rt by the constant shamt field
         mips_pkg::alu_sll:  result = op_b << dcd.shamt;
         mips_pkg::alu_srl:  result = op_b >> dcd.shamt;
         mips_pkg::alu_sra:  result = $signed(op_b) >>> dcd.shamt;
         mips_pkg::alu_lui:  result = {op_b[15:0], 16'h0000};
         default:            result = rs_data + op_b;
      endcase
   end

   // branches always compare the two registers, never the immediate
   always_comb begin
      case (dcd.branch)
         mips_pkg::br_beq:  taken = (rs_data == rt_data);
         mips_pkg::br_bne:  taken = (rs_data != rt_data);
         mips_pkg::br_jump: taken = 1'b1;
         default:           taken = 1'b0;
      endcase
   end

endmodule

// ==== rtl/mips_core.sv ====
// ===========================================================================
// mips_core
// single-cycle MIPS integer core, one instruction per clock with
// combinational instruction and data ports
// ===========================================================================
`timescale 1ns/1ns

module mips_core #(
   parameter mips_pkg::word_t text_start = 32'h0040_0000
) (
   input  logic            clk,
   input  logic            rst_b,
   output logic [29:0]     inst_addr,
   input  mips_pkg::word_t inst,
   output logic [29:0]     mem_addr,
   input  mips_pkg::word_t mem_rdata,
   output mips_pkg::word_t mem_wdata,
   output logic [3:0]      mem_we,
   output logic            halted
);

   mips_pkg::word_t rs_data;
   mips_pkg::word_t rt_data;
   mips_pkg::word_t result;
   mips_pkg::word_t wr_data;
   logic            taken;

   // decoded controls shared by every stage
   dcd_if dcd_bus ();

   inst_decoder dec_i (
      .inst (inst),
      .dcd  (dcd_bus)
   );

   pc_unit #(.text_start(text_start)) pc_i (
      .clk       (clk),
      .rst_b     (rst_b),
      .dcd       (dcd_bus),
      .taken     (taken),
      .inst_addr (inst_addr),
      .halted    (halted)
   );

   reg_file rf_i (
      .clk     (clk),
      .rst_b   (rst_b),
      .dcd     (dcd_bus),
      .wr_data (wr_data),
      .rs_data (rs_data),
      .rt_data (rt_data)
   );

   mips_alu alu_i (
      .dcd     (dcd_bus),
      .rs_data (rs_data),
      .rt_data (rt_data),
      .result  (result),
      .taken   (taken)
   );

   mem_stage mem_i (
      .dcd       (dcd_bus),
      .result    (result),
      .rt_data   (rt_data),
      .mem_rdata (mem_rdata),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_we    (mem_we),
      .wr_data   (wr_data)
   );

endmodule

// ==== rtl/mips_pkg.sv ====
// ===========================================================================
// mips_pkg
// shared word and register index types plus the opcode, funct, ALU,
// memory and control-flow encodings of the single-cycle MIPS core
// ===========================================================================
package mips_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_idx_t;

   // primary opcode, bits 31:26 of the instruction
   typedef enum logic [5:0] {
      op_special = 6'h00,
      op_j       = 6'h02,
      op_beq     = 6'h04,
      op_bne     = 6'h05,
      op_addiu   = 6'h09,
      op_slti    = 6'h0a,
      op_andi    = 6'h0c,
      op_ori     = 6'h0d,
      op_xori    = 6'h0e,
      op_lui     = 6'h0f,
      op_lw      = 6'h23,
      op_lbu     = 6'h24,
      op_sb      = 6'h28,
      op_sw      = 6'h2b
   } opcode_e;

   // secondary opcode for op_special, bits 5:0
   typedef enum logic [5:0] {
      fn_sll     = 6'h00,
      fn_srl     = 6'h02,
      fn_sra     = 6'h03,
      fn_syscall = 6'h0c,
      fn_addu    = 6'h21,
      fn_subu    = 6'h23,
      fn_and     = 6'h24,
      fn_or      = 6'h25,
      fn_xor     = 6'h26,
      fn_nor     = 6'h27,
      fn_slt     = 6'h2a,
      fn_sltu    = 6'h2b
   } funct_e;

   typedef enum logic [3:0] {
      alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor,
      alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra, alu_lui
   } alu_op_e;

   typedef enum logic [2:0] {
      mem_none, mem_lw, mem_lbu, mem_sw, mem_sb
   } mem_op_e;

   typedef enum logic [1:0] {
      br_none, br_beq, br_bne, br_jump
   } branch_e;

endpackage

// ==== rtl/pc_unit.sv ====
// ===========================================================================
// pc_unit
// program counter with next-PC selection for jumps and taken branches,
// plus the halt flag that freezes fetch after a syscall
// ===========================================================================
`timescale 1ns/1ns

module pc_unit #(
   parameter mips_pkg::word_t text_start = 32'h0040_0000
) (
   input  logic        clk,
   input  logic        rst_b,
   dcd_if.fetch        dcd,
   input  logic        taken,
   output logic [29:0] inst_addr,
   output logic        halted
);

   mips_pkg::word_t pc;
   mips_pkg::word_t pc_plus4;
   mips_pkg::word_t next_pc;

   assign pc_plus4 = pc + 32'd4;

   always_comb begin
      next_pc = pc_plus4;
      if (taken) begin
         if (dcd.branch == mips_pkg::br_jump) begin
            // pseudo-direct jump stays in the current 256MB region
            next_pc = {pc[31:28], dcd.target, 2'b00};
         end else begin
            next_pc = pc_plus4 + {dcd.imm[29:0], 2'b00};
         end
      end
   end

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         pc     <= text_start;
         halted <= 1'b0;
      end else begin
         halted <= halted | dcd.syscall;
         // pc parks on the syscall itself
         if (!halted && !dcd.syscall) begin
            pc <= next_pc;
         end
      end
   end

   assign inst_addr = pc[31:2];

   a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_b) pc[1:0] == 2'b00)
      else $error("pc lost word alignment");

endmodule

// ==== rtl/reg_file.sv ====
// ===========================================================================
// reg_file
// 32 x 32 general purpose registers, two combinational read ports and one
// write port updated on the clock edge
// ===========================================================================
`timescale 1ns/1ns

module reg_file (
   input  logic            clk,
   input  logic            rst_b,
   dcd_if.regs             dcd,
   input  mips_pkg::word_t wr_data,
   output mips_pkg::word_t rs_data,
   output mips_pkg::word_t rt_data
);

   mips_pkg::word_t regs [32];

   // entry 0 is cleared at reset and the decoder never enables a write to it
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (dcd.reg_we) begin
         regs[dcd.wr_idx] <= wr_data;
      end
   end

   assign rs_data = regs[dcd.rs];
   assign rt_data = regs[dcd.rt];

   a_zero_reg: assert property (@(posedge clk) disable iff (!rst_b)
      (dcd.rs == 5'd0) |-> (rs_data == '0))
      else $error("register zero read back nonzero");

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the single-cycle MIPS core testbench with Verilator
set -u
cd "$(dirname "$0")"

log=sim.log

verilator --binary --timing --assert -f build.f --top-module tb_mips_core -o sim_tb
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/sim_tb > "$log" 2>&1
status=$?

if grep -qF "*** TEST FAILED ***" "$log"; then
   echo "simulation reported failure, see $log"
   exit 1
fi
if [ $status -ne 0 ]; then
   echo "simulator exited with status $status, see $log"
   exit 1
fi
echo "simulation finished cleanly, see $log"
exit 0
